// ==== sim.f ====
+incdir+sim
design/sorted_lists_pkg.sv
design/list_table_ram.sv
design/update_pipe.sv
design/entry_sorter.sv
design/query_pipe.sv
design/sorted_lists.sv
sim/tb_clock_gen.sv
sim/tb_sorted_lists.sv

// ==== Bender.yml ====
package:
  name: sorted_lists

sources:
  - files:
      - design/sorted_lists_pkg.sv
      - design/list_table_ram.sv
      - design/update_pipe.sv
      - design/entry_sorter.sv
      - design/query_pipe.sv
      - design/sorted_lists.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_sorted_lists.sv

// ==== sim/tb_list_model.svh ====
`ifndef TB_LIST_MODEL_SVH
`define TB_LIST_MODEL_SVH

  // Model copy of every list with slot 0 at the lowest index
  entry_t model_slots [16][N_ENTRIES];

  logic [31:0] lfsr_state = 32'h7603_2b7d;

  // Galois step with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step for every bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Ends the run with a plain reason
  task automatic abort_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("error %s: %s expected 0x%0h, actual 0x%0h",
                          test_name, what, expected, actual));
    end
  endtask

  function automatic logic key_present(id_t id, key_t key);
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (model_slots[id][i].vld && (model_slots[id][i].key == key)) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Random key not yet valid in the list so the sort order stays unique
  function automatic key_t fresh_key(id_t id);
    key_t k;
    k = key_t'(rand_bits(16));
    while (key_present(id, k)) begin
      k = key_t'(rand_bits(16));
    end
    return k;
  endfunction

  // Applies one update in issue order and returns 1 when it fails
  function automatic logic model_update(upt_req_t r);
    int slot;
    slot = -1;
    if (r.op == OP_CLEAR) begin
      for (int i = 0; i < N_ENTRIES; i++) begin
        model_slots[r.id][i] = '0;
      end
      return 1'b0;
    end
    // First suitable slot counting up from index 0
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (slot < 0 && r.op == OP_ADD && !model_slots[r.id][i].vld) begin
        slot = i;
      end else if (slot < 0 && r.op != OP_ADD && model_slots[r.id][i].vld &&
                   model_slots[r.id][i].key == r.key) begin
        slot = i;
      end
    end
    if (slot < 0) begin
      return 1'b1;
    end
    case (r.op)
      OP_ADD:    model_slots[r.id][slot] = '{vld: 1'b1, key: r.key, size: r.size};
      OP_DELETE: model_slots[r.id][slot] = '0;
      default:   model_slots[r.id][slot].size = r.size;
    endcase
    return 1'b0;
  endfunction

  // Expected response picks a rank from the valid entries in ascending key order
  function automatic qry_resp_t model_query(qry_req_t q);
    entry_t    sorted [$];
    entry_t    e;
    qry_resp_t resp;
    int        pos;
    for (int i = 0; i < N_ENTRIES; i++) begin
      e = model_slots[q.id][i];
      if (e.vld) begin
        pos = 0;
        while (pos < sorted.size() && sorted[pos].key < e.key) begin
          pos++;
        end
        sorted.insert(pos, e);
      end
    end
    resp = '0;
    resp.count = count_t'(sorted.size());
    if (int'(q.rank) < sorted.size()) begin
      resp.key  = sorted[q.rank].key;
      resp.size = sorted[q.rank].size;
    end else begin
      resp.error = 1'b1;
    end
    return resp;
  endfunction

`endif

// ==== sim/tb_sorted_lists.sv ====
`timescale 1ns/10ps

module tb_sorted_lists;
  import sorted_lists_pkg::*;

  localparam int N_LISTS = 16;
  localparam int ROUNDS  = 40;

  // Expected error with the cycle it must show up in
  typedef struct packed {
    logic [31:0] cyc;
    id_t         id;
  } err_exp_t;

  // Expected query response with its cycle
  typedef struct packed {
    logic [31:0] cyc;
    qry_resp_t   resp;
  } resp_exp_t;

  logic      clk;
  logic      rst;
  logic      upt_vld;
  upt_req_t  upt_req;
  logic      upt_error_vld;
  id_t       upt_error_id;
  logic      qry_vld;
  qry_req_t  qry_req;
  logic      qry_resp_vld;
  qry_resp_t qry_resp;

  int        cyc = 0;
  string     test_name = "reset";
  err_exp_t  err_q [$];
  resp_exp_t resp_q [$];

  `include "tb_list_model.svh"

  tb_clock_gen i_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  sorted_lists #(
    .N_LISTS (N_LISTS)
  ) i_dut (
    .clk           (clk),
    .rst           (rst),
    .upt_vld       (upt_vld),
    .upt_req       (upt_req),
    .upt_error_vld (upt_error_vld),
    .upt_error_id  (upt_error_id),
    .qry_vld       (qry_vld),
    .qry_req       (qry_req),
    .qry_resp_vld  (qry_resp_vld),
    .qry_resp      (qry_resp)
  );

  // Cycle count that stamps every expectation
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Inputs change half a nanosecond after the edge
  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic idle(int n);
    upt_vld = 1'b0;
    qry_vld = 1'b0;
    repeat (n) next_cycle();
  endtask

  // Drive one update; a failing one must raise the error 3 cycles later
  task automatic issue_update(id_t id, op_t op, key_t key, size_t size);
    upt_req_t r;
    err_exp_t e;
    r = '{id: id, op: op, key: key, size: size};
    upt_vld = 1'b1;
    upt_req = r;
    if (model_update(r)) begin
      e = '{cyc: cyc + 3, id: id};
      err_q.push_back(e);
    end
    next_cycle();
  endtask

  // Response due exactly 5 cycles after issue
  task automatic issue_query(id_t id, rank_t rank);
    qry_req_t  q;
    resp_exp_t e;
    q = '{id: id, rank: rank};
    qry_vld = 1'b1;
    qry_req = q;
    e = '{cyc: cyc + 5, resp: model_query(q)};
    resp_q.push_back(e);
    next_cycle();
  endtask

  task automatic query_all();
    for (int i = 0; i < N_LISTS; i++) begin
      for (int r = 0; r < N_ENTRIES; r++) begin
        issue_query(id_t'(i), rank_t'(r));
      end
    end
    idle(1);
  endtask

  // Mostly adds so lists fill up and full-list errors occur
  task automatic random_update_to(id_t id);
    logic [3:0] pick;
    entry_t     e;
    key_t       key;
    pick = 4'(rand_bits(4));
    e = model_slots[id][rand_bits(2)];
    // Present key when the picked slot is valid and a random one otherwise
    key = e.vld ? e.key : key_t'(rand_bits(16));
    if (pick == 0) begin
      issue_update(id, OP_CLEAR, '0, '0);
    end else if (pick < 8) begin
      issue_update(id, OP_ADD, fresh_key(id), size_t'(rand_bits(8)));
    end else if (pick < 12) begin
      issue_update(id, OP_DELETE, key, '0);
    end else begin
      issue_update(id, OP_REPLACE, key, size_t'(rand_bits(8)));
    end
  endtask

  // Same id repeats often and hits the forwarding paths
  task automatic random_update(inout id_t last_id);
    id_t id;
    id = rand_bits(1) ? last_id : id_t'(rand_bits(4));
    last_id = id;
    random_update_to(id);
  endtask

  // Same id every cycle with a miss and a full-list add at the end
  task automatic hazard_burst(id_t id);
    key_t a;
    key_t b;
    issue_update(id, OP_CLEAR, '0, '0);
    a = fresh_key(id);
    issue_update(id, OP_ADD, a, 8'h11);
    issue_update(id, OP_DELETE, a, '0);
    issue_update(id, OP_ADD, a, 8'h22);
    b = fresh_key(id);
    issue_update(id, OP_ADD, b, 8'h33);
    issue_update(id, OP_REPLACE, b, 8'h44);
    issue_update(id, OP_DELETE, b, '0);
    issue_update(id, OP_REPLACE, b, 8'h55);
    repeat (4) issue_update(id, OP_ADD, fresh_key(id), size_t'(rand_bits(8)));
  endtask

  // Counted wait until every expected error and response was seen
  task automatic wait_drained(int max_cycles);
    int n;
    n = 0;
    while ((err_q.size() != 0 || resp_q.size() != 0) && n < max_cycles) begin
      next_cycle();
      n++;
    end
    if (err_q.size() != 0 || resp_q.size() != 0) begin
      abort_run("Timeout while waiting for update errors or query responses");
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      next_cycle();
      n++;
    end
    if (rst !== 1'b0) begin
      abort_run("Reset was never released");
    end
  endtask

  task automatic check_errors();
    if (upt_error_vld && (err_q.size() == 0 || err_q[0].cyc != cyc)) begin
      abort_run("Update error raised in a cycle where no failing update was due");
    end else if (upt_error_vld) begin
      check_value("error id", err_q[0].id, upt_error_id);
      void'(err_q.pop_front());
    end else if (err_q.size() != 0 && err_q[0].cyc == cyc) begin
      abort_run("Expected update error did not appear 3 cycles after issue");
    end
  endtask

  task automatic check_responses();
    resp_exp_t e;
    if (qry_resp_vld && (resp_q.size() == 0 || resp_q[0].cyc != cyc)) begin
      abort_run("Query response arrived in a cycle where none was due");
    end else if (qry_resp_vld) begin
      e = resp_q.pop_front();
      check_value("key", e.resp.key, qry_resp.key);
      check_value("size", e.resp.size, qry_resp.size);
      check_value("error flag", e.resp.error, qry_resp.error);
      check_value("count", e.resp.count, qry_resp.count);
    end else if (resp_q.size() != 0 && resp_q[0].cyc == cyc) begin
      abort_run("Query response missing 5 cycles after issue");
    end
  endtask

  // Outputs checked mid-cycle
  always begin
    @(posedge clk);
    #2;
    if (!rst) begin
      check_errors();
      check_responses();
    end
  end

  initial begin
    id_t last_id;
    id_t a;
    int  n_upd;
    int  n_qry;
    upt_vld = 1'b0;
    upt_req = '0;
    qry_vld = 1'b0;
    qry_req = '0;
    wait_reset();

    // Table has no reset so every list is cleared first
    test_name = "clear and count";
    for (int i = 0; i < N_LISTS; i++) begin
      issue_update(id_t'(i), OP_CLEAR, '0, '0);
    end
    idle(4);
    query_all();
    wait_drained(40);

    // Gaps of 1 to 4 cycles between updates to one id
    test_name = "back-to-back hazards";
    for (int g = 1; g <= 4; g++) begin
      a = id_t'(rand_bits(4));
      hazard_burst(a);
      for (int i = 0; i < 12; i++) begin
        random_update_to((i % g == 0) ? a : (a ^ id_t'(1)));
      end
    end
    idle(4);
    query_all();
    wait_drained(100);

    // Update burst and a quiet gap before queries on every cycle
    test_name = "random updates and queries";
    last_id = '0;
    for (int round = 0; round < ROUNDS; round++) begin
      n_upd = 4 + int'(rand_bits(4));
      repeat (n_upd) random_update(last_id);
      idle(4);
      n_qry = 4 + int'(rand_bits(4));
      repeat (n_qry) issue_query(id_t'(rand_bits(4)), rank_t'(rand_bits(2)));
      idle(1);
      wait_drained(50);
    end

    test_name = "final sweep";
    idle(4);
    query_all();
    wait_drained(100);
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real PERIOD     = 4.0,
  parameter int  RST_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  // Reset held over the first edges, released just after an edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #0.5;
    rst = 1'b0;
  end

endmodule

// ==== design/sorted_lists.sv ====
`timescale 1ns/10ps

module sorted_lists #(
  parameter int N_LISTS = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         upt_vld,
  input  sorted_lists_pkg::upt_req_t   upt_req,
  output logic                         upt_error_vld,
  output sorted_lists_pkg::id_t        upt_error_id,
  input  logic                         qry_vld,
  input  sorted_lists_pkg::qry_req_t   qry_req,
  output logic                         qry_resp_vld,
  output sorted_lists_pkg::qry_resp_t  qry_resp
);
  import sorted_lists_pkg::*;

  // Update copy read port
  logic  upt_rd_en;
  id_t   upt_rd_id;
  list_t upt_rd_list;

  // Query copy read port
  logic  qry_rd_en;
  id_t   qry_rd_id;
  list_t qry_rd_list;

  // Shared write bus into both copies
  logic  wr_en;
  id_t   wr_id;
  list_t wr_list;

  update_pipe #(
    .N_LISTS (N_LISTS)
  ) i_update_pipe (
    .clk           (clk),
    .rst           (rst),
    .upt_vld       (upt_vld),
    .upt_req       (upt_req),
    .rd_en         (upt_rd_en),
    .rd_id         (upt_rd_id),
    .rd_list       (upt_rd_list),
    .wr_en         (wr_en),
    .wr_id         (wr_id),
    .wr_list       (wr_list),
    .upt_error_vld (upt_error_vld),
    .upt_error_id  (upt_error_id)
  );

  query_pipe #(
    .N_LISTS (N_LISTS)
  ) i_query_pipe (
    .clk          (clk),
    .rst          (rst),
    .qry_vld      (qry_vld),
    .qry_req      (qry_req),
    .rd_en        (qry_rd_en),
    .rd_id        (qry_rd_id),
    .rd_list      (qry_rd_list),
    .qry_resp_vld (qry_resp_vld),
    .qry_resp     (qry_resp)
  );

  // Update copy
  list_table_ram #(
    .N_LISTS (N_LISTS)
  ) i_upt_table (
    .clk     (clk),
    .rd_en   (upt_rd_en),
    .rd_id   (upt_rd_id),
    .rd_list (upt_rd_list),
    .wr_en   (wr_en),
    .wr_id   (wr_id),
    .wr_list (wr_list)
  );

  // Query copy, written in lockstep
  list_table_ram #(
    .N_LISTS (N_LISTS)
  ) i_qry_table (
    .clk     (clk),
    .rd_en   (qry_rd_en),
    .rd_id   (qry_rd_id),
    .rd_list (qry_rd_list),
    .wr_en   (wr_en),
    .wr_id   (wr_id),
    .wr_list (wr_list)
  );

endmodule

// ==== design/query_pipe.sv ====
`timescale 1ns/10ps

module query_pipe #(
  parameter int N_LISTS = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         qry_vld,
  input  sorted_lists_pkg::qry_req_t   qry_req,
  output logic                         rd_en,
  output sorted_lists_pkg::id_t        rd_id,
  input  sorted_lists_pkg::list_t      rd_list,
  output logic                         qry_resp_vld,
  output sorted_lists_pkg::qry_resp_t  qry_resp
);
  import sorted_lists_pkg::*;

  // Same id folding as the update side
  localparam int  AW      = $clog2(N_LISTS);
  localparam id_t ID_MASK = id_t'((1 << AW) - 1);

  // Q0 waits for the read data
  logic     q0_vld;
  qry_req_t q0_req;
  // Q1 holds the unsorted list
  logic     q1_vld;
  qry_req_t q1_req;
  list_t    q1_list;

  // Sorter output
  logic     srt_vld;
  list_t    srt_list;
  qry_req_t srt_tag;

  entry_t   sel;
  count_t   cnt;

  // Read goes out with the accepted query
  assign rd_en = qry_vld;
  assign rd_id = qry_req.id & ID_MASK;

  always_ff @(posedge clk) begin
    if (rst) begin
      q0_vld       <= 1'b0;
      q1_vld       <= 1'b0;
      qry_resp_vld <= 1'b0;
    end else begin
      q0_vld       <= qry_vld;
      q1_vld       <= q0_vld;
      qry_resp_vld <= srt_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (qry_vld) begin
      q0_req <= qry_req;
    end
    if (q0_vld) begin
      q1_req  <= q0_req;
      q1_list <= rd_list;
    end
  end

  // Two more cycles of sorting
  entry_sorter i_sorter (
    .clk      (clk),
    .rst      (rst),
    .in_vld   (q1_vld),
    .in_list  (q1_list),
    .in_tag   (q1_req),
    .out_vld  (srt_vld),
    .out_list (srt_list),
    .out_tag  (srt_tag)
  );

  // Entry at the requested rank
  assign sel = srt_list[srt_tag.rank];

  // Valid entries in the list
  always_comb begin
    cnt = '0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      cnt = cnt + count_t'(srt_list[i].vld);
    end
  end

  // Response, key and size zero on an empty rank
  always_ff @(posedge clk) begin
    if (srt_vld) begin
      qry_resp.key   <= sel.vld ? sel.key : '0;
      qry_resp.size  <= sel.vld ? sel.size : '0;
      qry_resp.error <= ~sel.vld;
      qry_resp.count <= cnt;
    end
  end

endmodule

// ==== design/entry_sorter.sv ====
`timescale 1ns/10ps

module entry_sorter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_vld,
  input  sorted_lists_pkg::list_t     in_list,
  input  sorted_lists_pkg::qry_req_t  in_tag,
  output logic                        out_vld,
  output sorted_lists_pkg::list_t     out_list,
  output sorted_lists_pkg::qry_req_t  out_tag
);
  import sorted_lists_pkg::*;

  // First stage output
  logic     s1_vld;
  list_t    s1_list;
  qry_req_t s1_tag;

  // Network layers
  list_t    lay1;
  list_t    lay2;
  list_t    lay3;

  // True when a belongs after b: invalid last, then ascending key
  function automatic logic entry_after(entry_t a, entry_t b);
    if (a.vld != b.vld) begin
      return b.vld;
    end
    return a.vld && (a.key > b.key);
  endfunction

  // Compare-exchange of slots lo and hi
  function automatic list_t cmp_swap(list_t l, int lo, int hi);
    list_t r;
    r = l;
    if (entry_after(l[lo], l[hi])) begin
      r[lo] = l[hi];
      r[hi] = l[lo];
    end
    return r;
  endfunction

  // Layers 1 and 2 feed the first register
  // Layer 3 is the single middle comparator
  assign lay1 = cmp_swap(cmp_swap(in_list, 0, 1), 2, 3);
  assign lay2 = cmp_swap(cmp_swap(lay1, 0, 2), 1, 3);
  assign lay3 = cmp_swap(s1_list, 1, 2);

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld  <= 1'b0;
      out_vld <= 1'b0;
    end else begin
      s1_vld  <= in_vld;
      out_vld <= s1_vld;
    end
  end

  // Tag rides beside the data
  always_ff @(posedge clk) begin
    if (in_vld) begin
      s1_list <= lay2;
      s1_tag  <= in_tag;
    end
    if (s1_vld) begin
      out_list <= lay3;
      out_tag  <= s1_tag;
    end
  end

endmodule

// ==== design/update_pipe.sv ====
`timescale 1ns/10ps

module update_pipe #(
  parameter int N_LISTS = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        upt_vld,
  input  sorted_lists_pkg::upt_req_t  upt_req,
  output logic                        rd_en,
  output sorted_lists_pkg::id_t       rd_id,
  input  sorted_lists_pkg::list_t     rd_list,
  output logic                        wr_en,
  output sorted_lists_pkg::id_t       wr_id,
  output sorted_lists_pkg::list_t     wr_list,
  output logic                        upt_error_vld,
  output sorted_lists_pkg::id_t       upt_error_id
);
  import sorted_lists_pkg::*;

  // Ids beyond the table fold onto the low address bits
  localparam int  AW      = $clog2(N_LISTS);
  localparam id_t ID_MASK = id_t'((1 << AW) - 1);
  localparam int  SLOT_W  = $clog2(N_ENTRIES);

  // Stage valids
  logic              u0_vld;
  logic              u1_vld;
  logic              u2_vld;

  // U0 holds the request while the table read is in flight
  upt_req_t          u0_req;
  // U1 holds the request and its up-to-date list
  upt_req_t          u1_req;
  list_t             u1_list;
  // U2 holds the executed result
  id_t               u2_id;
  list_t             u2_list;
  logic              u2_err;

  // Copy of the last write, for the read that raced it
  logic              hold_vld;
  id_t               hold_id;
  list_t             hold_list;

  list_t             fwd_list;
  list_t             exec_list;
  logic              exec_err;
  logic              free_found;
  logic [SLOT_W-1:0] free_slot;
  logic              hit_found;
  logic [SLOT_W-1:0] hit_slot;

  // Ids that map to the same table row
  function automatic logic same_list(id_t a, id_t b);
    return ((a ^ b) & ID_MASK) == '0;
  endfunction

  // Table read goes out with the accepted request
  assign rd_en = upt_vld;
  assign rd_id = upt_req.id & ID_MASK;

  // Newest older result wins
  always_comb begin
    if (u1_vld && same_list(u1_req.id, u0_req.id)) begin
      fwd_list = exec_list;
    end else if (u2_vld && same_list(u2_id, u0_req.id)) begin
      fwd_list = u2_list;
    end else if (hold_vld && same_list(hold_id, u0_req.id)) begin
      fwd_list = hold_list;
    end else begin
      fwd_list = rd_list;
    end
  end

  // Lowest free slot and lowest matching slot
  // Scan runs downward so the last hit is the lowest index
  always_comb begin
    free_found = 1'b0;
    free_slot  = '0;
    hit_found  = 1'b0;
    hit_slot   = '0;
    for (int i = N_ENTRIES - 1; i >= 0; i--) begin
      if (!u1_list[i].vld) begin
        free_found = 1'b1;
        free_slot  = SLOT_W'(i);
      end
      if (u1_list[i].vld && (u1_list[i].key == u1_req.key)) begin
        hit_found = 1'b1;
        hit_slot  = SLOT_W'(i);
      end
    end
  end

  // Execute; a failed op leaves the list as it was
  always_comb begin
    exec_list = u1_list;
    exec_err  = 1'b0;
    case (u1_req.op)
      OP_CLEAR: begin
        exec_list = '0;
      end
      OP_ADD: begin
        if (free_found) begin
          exec_list[free_slot].vld  = 1'b1;
          exec_list[free_slot].key  = u1_req.key;
          exec_list[free_slot].size = u1_req.size;
        end else begin
          exec_err = 1'b1;
        end
      end
      OP_DELETE: begin
        if (hit_found) begin
          exec_list[hit_slot] = '0;
        end else begin
          exec_err = 1'b1;
        end
      end
      OP_REPLACE: begin
        if (hit_found) begin
          exec_list[hit_slot].size = u1_req.size;
        end else begin
          exec_err = 1'b1;
        end
      end
    endcase
  end

  // Valid chain
  always_ff @(posedge clk) begin
    if (rst) begin
      u0_vld   <= 1'b0;
      u1_vld   <= 1'b0;
      u2_vld   <= 1'b0;
      hold_vld <= 1'b0;
    end else begin
      u0_vld   <= upt_vld;
      u1_vld   <= u0_vld;
      u2_vld   <= u1_vld;
      hold_vld <= wr_en;
    end
  end

  // Stage payloads
  always_ff @(posedge clk) begin
    if (upt_vld) begin
      u0_req <= upt_req;
    end
    if (u0_vld) begin
      u1_req  <= u0_req;
      u1_list <= fwd_list;
    end
    if (u1_vld) begin
      u2_id   <= u1_req.id;
      u2_list <= exec_list;
      u2_err  <= exec_err;
    end
    if (wr_en) begin
      hold_id   <= wr_id;
      hold_list <= wr_list;
    end
  end

  // Writeback to both table copies
  assign wr_en   = u2_vld;
  assign wr_id   = u2_id & ID_MASK;
  assign wr_list = u2_list;

  // Error report, 3 cycles after accept
  assign upt_error_vld = u2_vld & u2_err;
  assign upt_error_id  = u2_id;

endmodule

// ==== design/list_table_ram.sv ====
`timescale 1ns/10ps

module list_table_ram #(
  parameter int N_LISTS = 16
) (
  input  logic                      clk,
  input  logic                      rd_en,
  input  sorted_lists_pkg::id_t     rd_id,
  output sorted_lists_pkg::list_t   rd_list,
  input  logic                      wr_en,
  input  sorted_lists_pkg::id_t     wr_id,
  input  sorted_lists_pkg::list_t   wr_list
);
  import sorted_lists_pkg::*;

  // One row per list id
  list_t mem [N_LISTS];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_id] <= wr_list;
    end
  end

  // Registered read port
  // Same-edge read of the row being written sees the old row
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_list <= mem[rd_id];
    end
  end

endmodule

// ==== design/sorted_lists_pkg.sv ====
package sorted_lists_pkg;

  // Entries per list; the sorting network is wired for exactly four
  localparam int N_ENTRIES = 4;

  // Field widths
  localparam int ID_W   = 4;
  localparam int KEY_W  = 16;
  localparam int SIZE_W = 8;

  typedef logic [ID_W-1:0]              id_t;
  typedef logic [KEY_W-1:0]             key_t;
  typedef logic [SIZE_W-1:0]            size_t;
  // Rank selects one of four sorted positions
  typedef logic [$clog2(N_ENTRIES)-1:0] rank_t;
  // Count runs 0..4, so one bit wider than a rank
  typedef logic [$clog2(N_ENTRIES):0]   count_t;

  // Update operations
  typedef enum logic [1:0] {
    OP_CLEAR   = 2'b00,
    OP_ADD     = 2'b01,
    OP_DELETE  = 2'b10,
    OP_REPLACE = 2'b11
  } op_t;

  // One slot of a list
  typedef struct packed {
    logic  vld;
    key_t  key;
    size_t size;
  } entry_t;

  // Whole list as stored in a table row
  typedef entry_t [N_ENTRIES-1:0] list_t;

  // Update request
  typedef struct packed {
    id_t   id;
    op_t   op;
    key_t  key;
    size_t size;
  } upt_req_t;

  // Query request, also used as the tag through the sorter
  typedef struct packed {
    id_t   id;
    rank_t rank;
  } qry_req_t;

  // Query response
  typedef struct packed {
    key_t   key;
    size_t  size;
    logic   error;
    count_t count;
  } qry_resp_t;

endpackage
